// File: video_text.f
design/video_text_pkg.sv
design/video_timing.sv
design/video_mem.sv
design/mem_arbiter.sv
design/row_fetcher.sv
design/glyph_pixel_unit.sv
design/video_text_top.sv
dv/video_text_checker.sv
dv/video_text_tb.sv

// File: Makefile
# Verilator build and run of the text-mode video controller testbench

VERILATOR ?= verilator
TOP       ?= video_text_tb
FILELIST  ?= video_text.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides, the simulator exit status alone is not trusted
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/video_text_tb.sv
`timescale 1ns/10ps

module video_text_tb;
	import video_text_pkg::*;

	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int N_TESTS      = 5;
	localparam int N_RAND       = 12;
	// three frames per test, two extra for reset and start-up
	localparam longint WATCHDOG_NS = longint'(N_TESTS * 3 + 2) * FRAME_CYCLES * 10;

	// one table row, either a host write or a pixel probe
	typedef struct {
		int                    test;
		bit                    probe;
		logic [MEM_ADDR_W-1:0] addr;
		cell_t                 data;
		int                    x;
		int                    y;
		int                    exp_idx;
	} step_t;

	logic                  pixel_clk_i;
	logic                  rstn_i;
	logic                  host_we_i;
	logic [MEM_ADDR_W-1:0] host_addr_i;
	cell_t                 host_wdata_i;
	logic                  host_busy_o;
	rgb_t                  rgb_o;
	logic                  hsync_o;
	logic                  vsync_o;
	logic                  de_o;

	step_t steps[$];
	string test_names[3] = '{"glyph and cell", "row and column edges", "random writes"};

	// host view of the video memory
	cell_t shadow_mem [2**MEM_ADDR_W];
	bit    shadow_known [2**MEM_ADDR_W];

	// probes of the test being run
	int   probe_x[$];
	int   probe_y[$];
	rgb_t probe_exp[$];
	bit   probe_hit[$];

	int errors = 0;
	int tests_failed = 0;
	// cycles a write spent waiting on host_busy_o
	int busy_waits = 0;

	video_text_top video_text_top_i (
		.pixel_clk_i  (pixel_clk_i),
		.rstn_i       (rstn_i),
		.host_we_i    (host_we_i),
		.host_addr_i  (host_addr_i),
		.host_wdata_i (host_wdata_i),
		.host_busy_o  (host_busy_o),
		.rgb_o        (rgb_o),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o),
		.de_o         (de_o)
	);

	bind video_text_top video_text_checker video_text_checker_i (
		.pixel_clk_i (pixel_clk_i),
		.rstn_i      (rstn_i),
		.hsync_i     (hsync_o),
		.vsync_i     (vsync_o),
		.de_i        (de_o),
		.host_we_i   (host_we_i),
		.host_busy_i (host_busy_o),
		.glyph_req_i (glyph_req),
		.row_req_i   (row_req),
		.mem_we_i    (mem_we)
	);

	initial begin
		pixel_clk_i = 1'b0;
		forever #5 pixel_clk_i = ~pixel_clk_i;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic compare_rgb(input string name, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("Error: %0t %s got %06h expected %06h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error: %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// blanking must be black on every cycle after reset
	always @(negedge pixel_clk_i) begin
		if (rstn_i && !de_o)
			compare_rgb("rgb_o in blanking", rgb_o, '0);
	end

	function automatic void push_write(input int test, input int addr, input logic [15:0] data);
		steps.push_back('{test, 1'b0, MEM_ADDR_W'(addr), cell_t'(data), 0, 0, 0});
	endfunction

	function automatic void queue_probe(input int test, input int x, input int y, input int idx);
		steps.push_back('{test, 1'b1, '0, cell_t'(16'h0), x, y, idx});
	endfunction

	// palette index of pixel (x, y) from the shadow memory, -1 if unknown
	function automatic int pixel_index(input int x, input int y);
		int         a;
		cell_t      c;
		logic [7:0] g;
		a = CELL_BASE + (y / GLYPH_H) * COLS + x / GLYPH_W;
		if (!shadow_known[a])
			return -1;
		c = shadow_mem[a];
		a = GLYPH_BASE + int'(c.code[6:0]) * GLYPH_H + y % GLYPH_H;
		if (!shadow_known[a])
			return -1;
		g = shadow_mem[a][7:0];
		// bit 7 is the leftmost pixel
		return g[7 - x % GLYPH_W] ? int'(c.fg) : int'(c.bg);
	endfunction

	// one strobe, held back while the previous write is pending
	task automatic host_write(input logic [MEM_ADDR_W-1:0] addr, input cell_t data);
		@(negedge pixel_clk_i);
		while (host_busy_o) begin
			busy_waits++;
			@(negedge pixel_clk_i);
		end
		host_we_i    = 1'b1;
		host_addr_i  = addr;
		host_wdata_i = data;
		shadow_mem[addr]   = data;
		shadow_known[addr] = 1'b1;
		@(negedge pixel_clk_i);
		host_we_i = 1'b0;
	endtask

	task automatic wait_commit();
		while (host_busy_o)
			@(negedge pixel_clk_i);
	endtask

	task automatic wait_vsync_rise();
		logic prev;
		prev = 1'b1;
		forever begin
			@(negedge pixel_clk_i);
			if (vsync_o && !prev)
				break;
			prev = vsync_o;
		end
	endtask

	// end of display line 15 of the next frame, the fetch of text row 1 is under way
	task automatic wait_row_fetch();
		int   lines;
		logic de_prev;
		wait_vsync_rise();
		lines = 0;
		de_prev = 1'b0;
		while (lines < GLYPH_H) begin
			@(negedge pixel_clk_i);
			if (de_prev && !de_o)
				lines++;
			de_prev = de_o;
		end
	endtask

	// walks the active area of the next frame and checks every probe
	task automatic capture_frame();
		int   x;
		int   y;
		logic de_prev;
		wait_vsync_rise();
		x = 0;
		y = 0;
		de_prev = 1'b0;
		while (y < V_ACTIVE) begin
			@(negedge pixel_clk_i);
			if (de_o) begin
				foreach (probe_x[i]) begin
					if (probe_x[i] == x && probe_y[i] == y) begin
						compare_rgb($sformatf("rgb_o at (%0d,%0d)", x, y), rgb_o, probe_exp[i]);
						probe_hit[i] = 1'b1;
					end
				end
				x++;
			end else if (de_prev) begin
				y++;
				x = 0;
			end
			de_prev = de_o;
		end
		foreach (probe_hit[i]) begin
			if (!probe_hit[i]) begin
				$display("probe at (%0d,%0d) was never shown", probe_x[i], probe_y[i]);
				errors++;
			end
		end
	endtask

	// sync, data-enable and cycle counts from one vsync rise to the next
	task automatic measure_raster();
		int   total;
		int   hs;
		int   vs;
		int   de;
		logic vs_prev;
		total = 0;
		hs = 0;
		vs = 0;
		de = 0;
		wait_vsync_rise();
		do begin
			total++;
			hs += int'(hsync_o);
			vs += int'(vsync_o);
			de += int'(de_o);
			vs_prev = vsync_o;
			@(negedge pixel_clk_i);
		end while (!(vsync_o && !vs_prev));
		compare_count("frame cycles", total, FRAME_CYCLES);
		compare_count("hsync_o high cycles", hs, (H_SYNC_END - H_SYNC_START) * V_TOTAL);
		compare_count("vsync_o high cycles", vs, (V_SYNC_END - V_SYNC_START) * H_TOTAL);
		compare_count("de_o high cycles", de, H_ACTIVE * V_ACTIVE);
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
			tests_failed++;
		end
	endtask

	initial begin
		int   err_before;
		int   r;
		int   c;
		int   k;
		int   gy;
		int   idx;
		rgb_t exp;

		void'($urandom(35));
		rstn_i       = 1'b0;
		host_we_i    = 1'b0;
		host_addr_i  = '0;
		host_wdata_i = cell_t'(16'h0);

		// test 0: glyph 0x41 at row 2 column 5, yellow on blue
		push_write(0, 2 * COLS + 5, 16'h41e1);
		push_write(0, GLYPH_BASE + 65 * GLYPH_H + 3, 16'h0081);
		push_write(0, GLYPH_BASE + 65 * GLYPH_H + 4, 16'h003c);
		queue_probe(0, 40, 35, 14);
		queue_probe(0, 41, 35, 1);
		queue_probe(0, 47, 35, 14);
		queue_probe(0, 41, 36, 1);
		queue_probe(0, 42, 36, 14);
		// test 1: code 0x7f in three corner cells, only the rightmost bit of row 15 set
		push_write(1, GLYPH_BASE + 127 * GLYPH_H + 15, 16'h0001);
		push_write(1, 29 * COLS + 79, 16'h7f4a);
		push_write(1, 79, 16'h7f25);
		push_write(1, 29 * COLS, 16'h7f3c);
		queue_probe(1, 632, 479, 10);
		queue_probe(1, 639, 479, 4);
		queue_probe(1, 632, 15, 5);
		queue_probe(1, 639, 15, 2);
		queue_probe(1, 0, 479, 12);
		queue_probe(1, 7, 479, 3);
		// test 2: random cells and glyph rows, expected values from the shadow model
		for (int i = 0; i < N_RAND; i++) begin
			r  = $urandom % ROWS;
			c  = $urandom % COLS;
			k  = $urandom % 128;
			gy = $urandom % GLYPH_H;
			push_write(2, r * COLS + c, {8'(k), 8'($urandom)});
			push_write(2, GLYPH_BASE + k * GLYPH_H + gy, {8'h00, 8'($urandom)});
			queue_probe(2, c * GLYPH_W + $urandom % GLYPH_W, r * GLYPH_H + gy, -1);
		end

		// reset values, checked while reset is held
		repeat (3) @(negedge pixel_clk_i);
		err_before = errors;
		compare_bit("host_busy_o", host_busy_o, 1'b0);
		compare_bit("hsync_o", hsync_o, 1'b0);
		compare_bit("vsync_o", vsync_o, 1'b0);
		compare_bit("de_o", de_o, 1'b0);
		compare_rgb("rgb_o", rgb_o, '0);
		repeat (2) @(negedge pixel_clk_i);
		rstn_i = 1'b1;
		report_test("reset values", err_before);

		err_before = errors;
		measure_raster();
		report_test("raster timing", err_before);

		for (int t = 0; t < 3; t++) begin
			err_before = errors;
			probe_x.delete();
			probe_y.delete();
			probe_exp.delete();
			probe_hit.delete();
			// random writes start inside a row fetch and queue behind it
			if (t == 2)
				wait_row_fetch();
			busy_waits = 0;
			foreach (steps[i]) begin
				if (steps[i].test == t && !steps[i].probe)
					host_write(steps[i].addr, steps[i].data);
			end
			wait_commit();
			if (t == 2 && busy_waits == 0) begin
				$display("random writes never had to wait on host_busy_o");
				errors++;
			end
			foreach (steps[i]) begin
				if (steps[i].test == t && steps[i].probe) begin
					idx = steps[i].exp_idx;
					if (idx < 0)
						idx = pixel_index(steps[i].x, steps[i].y);
					if (idx < 0) begin
						$display("probe at (%0d,%0d) skipped, its glyph row is unknown",
							steps[i].x, steps[i].y);
					end else begin
						exp = PALETTE[idx];
						probe_x.push_back(steps[i].x);
						probe_y.push_back(steps[i].y);
						probe_exp.push_back(exp);
						probe_hit.push_back(1'b0);
					end
				end
			end
			capture_frame();
			report_test(test_names[t], err_before);
		end

		errors += video_text_top_i.video_text_checker_i.fail_count;
		$display("tests: %0d run, %0d failed, %0d errors", N_TESTS, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: dv/video_text_checker.sv
`timescale 1ns/10ps

module video_text_checker (
	input logic pixel_clk_i,
	input logic rstn_i,
	input logic hsync_i,
	input logic vsync_i,
	input logic de_i,
	input logic host_we_i,
	input logic host_busy_i,
	input logic glyph_req_i,
	input logic row_req_i,
	input logic mem_we_i
);
	import video_text_pkg::*;

	// number of failed assertions, read by the testbench at the end
	int fail_count = 0;

	// consecutive high cycles of each sync
	int hs_len;
	int vs_len;

	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			hs_len <= 0;
			vs_len <= 0;
		end else begin
			hs_len <= hsync_i ? hs_len + 1 : 0;
			vs_len <= vsync_i ? vs_len + 1 : 0;
		end
	end

	// 96 pixels of hsync
	hsync_width: assert property (@(posedge pixel_clk_i) disable iff (!rstn_i)
		$fell(hsync_i) |-> (hs_len == H_SYNC_END - H_SYNC_START))
		else begin
			fail_count++;
			$error("hsync pulse lasted %0d cycles", hs_len);
		end

	// two full lines of vsync
	vsync_width: assert property (@(posedge pixel_clk_i) disable iff (!rstn_i)
		$fell(vsync_i) |-> (vs_len == (V_SYNC_END - V_SYNC_START) * H_TOTAL))
		else begin
			fail_count++;
			$error("vsync pulse lasted %0d cycles", vs_len);
		end

	no_de_in_sync: assert property (@(posedge pixel_clk_i) disable iff (!rstn_i)
		!(de_i && (hsync_i || vsync_i)))
		else begin
			fail_count++;
			$error("de_o high during a sync pulse");
		end

	// glyph read, row read and host write never share a cycle,
	// so the glyph reader and the row fetcher are granted whenever they ask
	one_grant: assert property (@(posedge pixel_clk_i) disable iff (!rstn_i)
		$onehot0({glyph_req_i, row_req_i, mem_we_i}))
		else begin
			fail_count++;
			$error("more than one memory access wanted in a cycle");
		end

	no_strobe_when_busy: assert property (@(posedge pixel_clk_i) disable iff (!rstn_i)
		!(host_we_i && host_busy_i))
		else begin
			fail_count++;
			$error("host write strobe while host_busy_o is high");
		end

endmodule

// File: design/video_text_top.sv
`timescale 1ns/10ps

module video_text_top (
	input  logic                                   pixel_clk_i,
	input  logic                                   rstn_i,
	input  logic                                   host_we_i,
	input  logic [video_text_pkg::MEM_ADDR_W-1:0]  host_addr_i,
	input  video_text_pkg::cell_t                  host_wdata_i,
	output logic                                   host_busy_o,
	output video_text_pkg::rgb_t                   rgb_o,
	output logic                                   hsync_o,
	output logic                                   vsync_o,
	output logic                                   de_o
);
	import video_text_pkg::*;

	// timing strobes
	logic                   glyph_slot;
	logic                   row_fetch_start;
	logic [ROW_IDX_W-1:0]   row_idx;
	logic [COL_IDX_W-1:0]   ahead_col;
	logic [GLYPH_ROW_W-1:0] glyph_row;

	// line buffer read port
	logic [COL_IDX_W-1:0]   lb_col;
	cell_t                  lb_cell;

	// peer requests and returns
	logic                   glyph_req;
	logic [MEM_ADDR_W-1:0]  glyph_addr;
	logic                   glyph_valid;
	logic                   row_req;
	logic [MEM_ADDR_W-1:0]  row_addr;
	logic                   row_gnt;
	logic                   row_valid;

	// memory port
	logic                   mem_en;
	logic                   mem_we;
	logic [MEM_ADDR_W-1:0]  mem_addr;
	cell_t                  mem_wdata;
	cell_t                  mem_rdata;

	video_timing video_timing_i (
		.pixel_clk_i       (pixel_clk_i),
		.rstn_i            (rstn_i),
		.hsync_o           (hsync_o),
		.vsync_o           (vsync_o),
		.de_o              (de_o),
		.glyph_slot_o      (glyph_slot),
		.row_fetch_start_o (row_fetch_start),
		.row_idx_o         (row_idx),
		.ahead_col_o       (ahead_col),
		.glyph_row_o       (glyph_row)
	);

	row_fetcher row_fetcher_i (
		.pixel_clk_i       (pixel_clk_i),
		.rstn_i            (rstn_i),
		.row_fetch_start_i (row_fetch_start),
		.row_idx_i         (row_idx),
		.row_gnt_i         (row_gnt),
		.row_valid_i       (row_valid),
		.mem_rdata_i       (mem_rdata),
		.row_req_o         (row_req),
		.row_addr_o        (row_addr),
		.lb_col_i          (lb_col),
		.lb_cell_o         (lb_cell)
	);

	glyph_pixel_unit glyph_pixel_unit_i (
		.pixel_clk_i   (pixel_clk_i),
		.rstn_i        (rstn_i),
		.glyph_slot_i  (glyph_slot),
		.ahead_col_i   (ahead_col),
		.glyph_row_i   (glyph_row),
		.lb_cell_i     (lb_cell),
		.glyph_valid_i (glyph_valid),
		.mem_rdata_i   (mem_rdata),
		.lb_col_o      (lb_col),
		.glyph_req_o   (glyph_req),
		.glyph_addr_o  (glyph_addr),
		.rgb_o         (rgb_o)
	);

	// fixed priority, glyph reader first and host last
	mem_arbiter mem_arbiter_i (
		.pixel_clk_i   (pixel_clk_i),
		.rstn_i        (rstn_i),
		.glyph_req_i   (glyph_req),
		.glyph_addr_i  (glyph_addr),
		.row_req_i     (row_req),
		.row_addr_i    (row_addr),
		.host_we_i     (host_we_i),
		.host_addr_i   (host_addr_i),
		.host_wdata_i  (host_wdata_i),
		.row_gnt_o     (row_gnt),
		.glyph_valid_o (glyph_valid),
		.row_valid_o   (row_valid),
		.host_busy_o   (host_busy_o),
		.mem_en_o      (mem_en),
		.mem_we_o      (mem_we),
		.mem_addr_o    (mem_addr),
		.mem_wdata_o   (mem_wdata)
	);

	video_mem video_mem_i (
		.pixel_clk_i (pixel_clk_i),
		.en_i        (mem_en),
		.we_i        (mem_we),
		.addr_i      (mem_addr),
		.wdata_i     (mem_wdata),
		.rdata_o     (mem_rdata)
	);

endmodule

// File: design/glyph_pixel_unit.sv
`timescale 1ns/10ps

module glyph_pixel_unit (
	input  logic                                   pixel_clk_i,
	input  logic                                   rstn_i,
	input  logic                                   glyph_slot_i,
	input  logic [video_text_pkg::COL_IDX_W-1:0]   ahead_col_i,
	input  logic [video_text_pkg::GLYPH_ROW_W-1:0] glyph_row_i,
	input  video_text_pkg::cell_t                  lb_cell_i,
	input  logic                                   glyph_valid_i,
	input  video_text_pkg::cell_t                  mem_rdata_i,
	output logic [video_text_pkg::COL_IDX_W-1:0]   lb_col_o,
	output logic                                   glyph_req_o,
	output logic [video_text_pkg::MEM_ADDR_W-1:0]  glyph_addr_o,
	output video_text_pkg::rgb_t                   rgb_o
);
	import video_text_pkg::*;

	// pipeline for a character whose slot is at cycle t
	// t    line buffer read at the lookahead column
	// t+1  cell latched, glyph row requested
	// t+2  glyph row at the memory output, loaded into the shifter
	// t+3  palette lookup of the first pixel
	// t+4  rgb_o valid, the display counter has caught up by LOOKAHEAD

	// stage 1
	logic                   slot_q;
	cell_t                  cell_q;
	logic [GLYPH_ROW_W-1:0] row_q;

	// stage 2, bits leave from the top, bit 7 is the leftmost pixel
	logic [GLYPH_W-1:0] bits_q;
	// marks the pixels that belong to a visible character
	logic [GLYPH_W-1:0] mask_q;
	logic [3:0]         fg_q;
	logic [3:0]         bg_q;

	assign lb_col_o = ahead_col_i;

	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i)
			slot_q <= 1'b0;
		else
			slot_q <= glyph_slot_i;
	end

	always_ff @(posedge pixel_clk_i) begin
		if (glyph_slot_i) begin
			cell_q <= lb_cell_i;
			row_q  <= glyph_row_i;
		end
	end

	// only codes below 128 have glyphs
	assign glyph_req_o  = slot_q;
	assign glyph_addr_o = MEM_ADDR_W'(GLYPH_BASE + cell_q.code[6:0] * GLYPH_H + row_q);

	// colours travel with the glyph bits, cell_q is overwritten by the next slot
	// before the last pixel of this character is shown
	always_ff @(posedge pixel_clk_i) begin
		if (glyph_valid_i) begin
			bits_q <= mem_rdata_i[GLYPH_W-1:0];
			fg_q   <= cell_q.fg;
			bg_q   <= cell_q.bg;
		end else begin
			bits_q <= bits_q << 1;
		end
	end

	// the mask runs out eight pixels after the last glyph of a line
	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i)
			mask_q <= '0;
		else if (glyph_valid_i)
			mask_q <= '1;
		else
			mask_q <= mask_q << 1;
	end

	// black in blanking
	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i)
			rgb_o <= '0;
		else if (mask_q[GLYPH_W-1])
			rgb_o <= PALETTE[bits_q[GLYPH_W-1] ? fg_q : bg_q];
		else
			rgb_o <= '0;
	end

endmodule

// File: design/row_fetcher.sv
`timescale 1ns/10ps

module row_fetcher (
	input  logic                                   pixel_clk_i,
	input  logic                                   rstn_i,
	input  logic                                   row_fetch_start_i,
	input  logic [video_text_pkg::ROW_IDX_W-1:0]   row_idx_i,
	input  logic                                   row_gnt_i,
	input  logic                                   row_valid_i,
	input  video_text_pkg::cell_t                  mem_rdata_i,
	output logic                                   row_req_o,
	output logic [video_text_pkg::MEM_ADDR_W-1:0]  row_addr_o,
	input  logic [video_text_pkg::COL_IDX_W-1:0]   lb_col_i,
	output video_text_pkg::cell_t                  lb_cell_o
);
	import video_text_pkg::*;

	fetch_state_e state_q, state_d;

	// next cell address to request
	logic [MEM_ADDR_W-1:0] addr_q;
	// column of the next request and of the next returning cell
	logic [COL_IDX_W-1:0]  req_col_q;
	logic [COL_IDX_W-1:0]  wr_col_q;

	// one text row of cells
	cell_t lb [COLS];

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (row_fetch_start_i)
					state_d = FETCH;
			end
			FETCH: begin
				// last request accepted, wait for its data
				if (row_gnt_i && (req_col_q == COL_IDX_W'(COLS - 1)))
					state_d = DRAIN;
			end
			DRAIN: begin
				if (row_valid_i && (wr_col_q == COL_IDX_W'(COLS - 1)))
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q   <= IDLE;
			addr_q    <= '0;
			req_col_q <= '0;
			wr_col_q  <= '0;
		end else begin
			state_q <= state_d;
			if ((state_q == IDLE) && row_fetch_start_i) begin
				addr_q    <= MEM_ADDR_W'(CELL_BASE + row_idx_i * COLS);
				req_col_q <= '0;
				wr_col_q  <= '0;
			end else begin
				// a refused request is simply repeated next cycle
				if ((state_q == FETCH) && row_gnt_i) begin
					addr_q    <= addr_q + 1'b1;
					req_col_q <= req_col_q + 1'b1;
				end
				if (row_valid_i)
					wr_col_q <= wr_col_q + 1'b1;
			end
		end
	end

	// cells come back in request order
	always_ff @(posedge pixel_clk_i) begin
		if (row_valid_i)
			lb[wr_col_q] <= mem_rdata_i;
	end

	assign row_req_o  = (state_q == FETCH);
	assign row_addr_o = addr_q;

	// read side for the pixel unit
	assign lb_cell_o = lb[lb_col_i];

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
	input  logic                                   pixel_clk_i,
	input  logic                                   rstn_i,
	input  logic                                   glyph_req_i,
	input  logic [video_text_pkg::MEM_ADDR_W-1:0]  glyph_addr_i,
	input  logic                                   row_req_i,
	input  logic [video_text_pkg::MEM_ADDR_W-1:0]  row_addr_i,
	input  logic                                   host_we_i,
	input  logic [video_text_pkg::MEM_ADDR_W-1:0]  host_addr_i,
	input  video_text_pkg::cell_t                  host_wdata_i,
	output logic                                   row_gnt_o,
	output logic                                   glyph_valid_o,
	output logic                                   row_valid_o,
	output logic                                   host_busy_o,
	output logic                                   mem_en_o,
	output logic                                   mem_we_o,
	output logic [video_text_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
	output video_text_pkg::cell_t                  mem_wdata_o
);
	import video_text_pkg::*;

	// one pending host write
	logic                  pend_q;
	logic [MEM_ADDR_W-1:0] pend_addr_q;
	cell_t                 pend_wdata_q;

	// requester owning the memory this cycle, and the one from last cycle
	mem_req_e gnt;
	mem_req_e gnt_q;

	// glyph reader first, it has no way to wait
	always_comb begin
		if (glyph_req_i)
			gnt = GLYPH;
		else if (row_req_i)
			gnt = ROW;
		else if (pend_q)
			gnt = HOST;
		else
			gnt = NONE;
	end

	always_comb begin
		case (gnt)
			GLYPH:   mem_addr_o = glyph_addr_i;
			ROW:     mem_addr_o = row_addr_i;
			default: mem_addr_o = pend_addr_q;
		endcase
	end

	assign mem_en_o    = (gnt != NONE);
	assign mem_we_o    = (gnt == HOST);
	assign mem_wdata_o = pend_wdata_q;
	assign row_gnt_o   = (gnt == ROW);

	// a strobe while a write is still pending is lost
	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			pend_q <= 1'b0;
			gnt_q  <= NONE;
		end else begin
			gnt_q <= gnt;
			if (!pend_q)
				pend_q <= host_we_i;
			else if (gnt == HOST)
				pend_q <= 1'b0;
		end
	end

	always_ff @(posedge pixel_clk_i) begin
		if (host_we_i && !pend_q) begin
			pend_addr_q  <= host_addr_i;
			pend_wdata_q <= host_wdata_i;
		end
	end

	// read data sits at the memory output one cycle after the grant
	assign glyph_valid_o = (gnt_q == GLYPH);
	assign row_valid_o   = (gnt_q == ROW);
	assign host_busy_o   = pend_q;

endmodule

// File: design/video_mem.sv
`timescale 1ns/10ps

module video_mem (
	input  logic                                   pixel_clk_i,
	input  logic                                   en_i,
	input  logic                                   we_i,
	input  logic [video_text_pkg::MEM_ADDR_W-1:0]  addr_i,
	input  video_text_pkg::cell_t                  wdata_i,
	output video_text_pkg::cell_t                  rdata_o
);
	import video_text_pkg::*;

	// cells in the low half, glyph rows from GLYPH_BASE up
	cell_t mem [2**MEM_ADDR_W];

	// single port, read data registered one cycle after the access
	always_ff @(posedge pixel_clk_i) begin
		if (en_i) begin
			if (we_i)
				mem[addr_i] <= wdata_i;
			else
				rdata_o <= mem[addr_i];
		end
	end

endmodule

// File: design/video_timing.sv
`timescale 1ns/10ps

module video_timing (
	input  logic                                    pixel_clk_i,
	input  logic                                    rstn_i,
	output logic                                    hsync_o,
	output logic                                    vsync_o,
	output logic                                    de_o,
	output logic                                    glyph_slot_o,
	output logic                                    row_fetch_start_o,
	output logic [video_text_pkg::ROW_IDX_W-1:0]    row_idx_o,
	output logic [video_text_pkg::COL_IDX_W-1:0]    ahead_col_o,
	output logic [video_text_pkg::GLYPH_ROW_W-1:0]  glyph_row_o
);
	import video_text_pkg::*;

	// display position and lookahead position, the latter LOOKAHEAD pixels in front
	logic [CNT_W-1:0] x_q, y_q;
	logic [CNT_W-1:0] x_nxt, y_nxt;
	logic [CNT_W-1:0] ax_q, ay_q;
	logic [CNT_W-1:0] ax_nxt, ay_nxt;

	function automatic logic [CNT_W-1:0] step_x(input logic [CNT_W-1:0] x);
		return (x == CNT_W'(H_TOTAL - 1)) ? '0 : x + 1'b1;
	endfunction

	// y only moves when x wraps
	function automatic logic [CNT_W-1:0] step_y(input logic [CNT_W-1:0] x,
			input logic [CNT_W-1:0] y);
		logic [CNT_W-1:0] y_n;
		y_n = y;
		if (x == CNT_W'(H_TOTAL - 1))
			y_n = (y == CNT_W'(V_TOTAL - 1)) ? '0 : y + 1'b1;
		return y_n;
	endfunction

	assign x_nxt  = step_x(x_q);
	assign y_nxt  = step_y(x_q, y_q);
	assign ax_nxt = step_x(ax_q);
	assign ay_nxt = step_y(ax_q, ay_q);

	// syncs come from the next display position so they line up with the
	// registered rgb of the pixel unit
	always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			x_q     <= '0;
			y_q     <= CNT_W'(RESET_LINE);
			ax_q    <= CNT_W'(LOOKAHEAD);
			ay_q    <= CNT_W'(RESET_LINE);
			hsync_o <= 1'b0;
			vsync_o <= 1'b0;
			de_o    <= 1'b0;
		end else begin
			x_q     <= x_nxt;
			y_q     <= y_nxt;
			ax_q    <= ax_nxt;
			ay_q    <= ay_nxt;
			hsync_o <= (x_nxt >= CNT_W'(H_SYNC_START)) && (x_nxt < CNT_W'(H_SYNC_END));
			vsync_o <= (y_nxt >= CNT_W'(V_SYNC_START)) && (y_nxt < CNT_W'(V_SYNC_END));
			de_o    <= (x_nxt < CNT_W'(H_ACTIVE)) && (y_nxt < CNT_W'(V_ACTIVE));
		end
	end

	// one glyph slot at the first pixel of every visible character
	assign glyph_slot_o = (ax_q < CNT_W'(H_ACTIVE)) && (ay_q < CNT_W'(V_ACTIVE)) &&
		(ax_q[$clog2(GLYPH_W)-1:0] == '0);

	assign ahead_col_o = ax_q[$clog2(GLYPH_W) +: COL_IDX_W];
	assign glyph_row_o = ay_q[GLYPH_ROW_W-1:0];

	// fetch on the last scanline of a text row, or on the last line of the
	// frame for row 0; row 29 is the last one and needs no follower
	assign row_fetch_start_o = (ax_q == CNT_W'(H_ACTIVE)) &&
		(((ay_q[GLYPH_ROW_W-1:0] == GLYPH_ROW_W'(GLYPH_H - 1)) &&
		(ay_q < CNT_W'(V_ACTIVE - 1))) || (ay_q == CNT_W'(V_TOTAL - 1)));

	assign row_idx_o = (ay_q == CNT_W'(V_TOTAL - 1)) ? '0 :
		ay_q[GLYPH_ROW_W +: ROW_IDX_W] + 1'b1;

endmodule

// File: design/video_text_pkg.sv
package video_text_pkg;

	// 640x480 at 60 Hz, 800x525 total with blanking
	localparam int H_ACTIVE     = 640;
	localparam int H_SYNC_START = 656;
	localparam int H_SYNC_END   = 752;
	localparam int H_TOTAL      = 800;

	localparam int V_ACTIVE     = 480;
	localparam int V_SYNC_START = 490;
	localparam int V_SYNC_END   = 492;
	localparam int V_TOTAL      = 525;

	// raster counter width and the scanline the counters leave reset on
	localparam int CNT_W      = 10;
	localparam int RESET_LINE = 481;

	// text grid of 8x16 glyphs
	localparam int COLS    = 80;
	localparam int ROWS    = 30;
	localparam int GLYPH_W = 8;
	localparam int GLYPH_H = 16;

	localparam int COL_IDX_W   = 7;
	localparam int ROW_IDX_W   = 5;
	localparam int GLYPH_ROW_W = 4;

	// lead of the lookahead counters, equal to the pixel pipeline depth
	localparam int LOOKAHEAD = 4;

	// video memory map
	localparam int MEM_ADDR_W = 13;
	localparam int CELL_BASE  = 0;
	localparam int GLYPH_BASE = 4096;

	// one character cell, code in the top byte
	typedef struct packed {
		logic [7:0] code;
		logic [3:0] fg;
		logic [3:0] bg;
	} cell_t;

	// red in the top byte, blue in the bottom one
	typedef logic [23:0] rgb_t;

	// standard CGA colours
	localparam rgb_t PALETTE [16] = '{
		24'h000000, 24'h0000aa, 24'h00aa00, 24'h00aaaa,
		24'haa0000, 24'haa00aa, 24'haa5500, 24'haaaaaa,
		24'h555555, 24'h5555ff, 24'h55ff55, 24'h55ffff,
		24'hff5555, 24'hff55ff, 24'hffff55, 24'hffffff
	};

	// memory requesters, in falling priority
	typedef enum logic [1:0] {
		GLYPH,
		ROW,
		HOST,
		NONE
	} mem_req_e;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DRAIN
	} fetch_state_e;

endpackage
